//--- hdl/lsu_pkg.sv
/*
 * core-side definitions for the load/store unit
 * access size encoding, data word union, data width
 */

`default_nettype none

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////
  // core side
  ////////////////////////////////////////////////////////////////////

  localparam int XLEN  = 32;  // core data width
  localparam int OFF_W = 2;   // byte offset inside a word

  // access size, value 3 decodes as a byte
  typedef enum logic [1:0] {
    LSU_WORD = 2'd0,
    LSU_HALF = 2'd1,
    LSU_BYTE = 2'd2
  } lsu_type_e;

  ////////////////////////////////////////////////////////////////////
  // data word, little-endian lanes
  ////////////////////////////////////////////////////////////////////

  typedef union packed {
    logic [3:0][7:0]  b;  // b[0] is the lowest address
    logic [1:0][15:0] h;  // h[0] covers bytes 0 and 1
  } lsu_word_u;

endpackage

`default_nettype wire

//--- hdl/wb_pkg.sv
/*
 * Wishbone bus widths and default memory size
 */

`default_nettype none

package wb_pkg;

  localparam int WB_SEL_W          = 4;    // one select per byte lane
  localparam int WB_ADR_LSB        = 2;    // lowest word address bit
  localparam int MEM_WORDS_DEFAULT = 256;  // power of two

endpackage

`default_nettype wire

//--- hdl/lsu_align.sv
/*
 * load/store alignment: byte selects, write data rotation,
 * read realignment with sign/zero extension, error qualification
 */

`timescale 1ns/100ps
`default_nettype none

module lsu_align import lsu_pkg::*; import wb_pkg::*; (
  // request side, live at acceptance
  input  logic [1:0]          lsu_type_i,
  input  logic [OFF_W-1:0]    lsu_addr_lo_i,
  input  logic [XLEN-1:0]     lsu_wdata_i,
  // bus response
  input  lsu_word_u           wb_rdata_i,
  input  logic                wb_ack_i,
  input  logic                wb_err_i,
  // held access state from the controller
  input  logic [23:0]         rdata_q_i,         // bytes 3..1 of the first word
  input  logic [OFF_W-1:0]    rdata_offset_q_i,
  input  logic [1:0]          data_type_q_i,
  input  logic                data_sign_ext_q_i,
  input  logic                data_we_q_i,
  input  logic                split_second_q_i,
  input  logic                err_q_i,
  // outputs
  output logic [WB_SEL_W-1:0] data_be_o,
  output logic [XLEN-1:0]     data_wdata_o,
  output logic                split_access_o,
  output logic [XLEN-1:0]     lsu_rdata_o,
  output logic                lsu_rdata_valid_o,
  output logic                load_err_o,
  output logic                store_err_o
);

  logic [2*WB_SEL_W-1:0] be_first;   // selects over two words, live request
  logic [2*WB_SEL_W-1:0] be_held;    // same for the held access
  logic                  split_held;
  logic                  spill_next; // first half of a split just acked
  logic                  final_half; // ack on this cycle ends the access
  logic                  resp;
  logic                  any_err;
  logic [XLEN-1:0]       rdata_w;
  logic [15:0]           half_raw;
  logic [7:0]            byte_raw;

  // selects of an access spread across two adjacent words
  function automatic logic [2*WB_SEL_W-1:0] be_span(logic [1:0] typ, logic [OFF_W-1:0] off);
    logic [2*WB_SEL_W-1:0] base;
    case (typ)
      LSU_WORD: base = 8'h0f;
      LSU_HALF: base = 8'h03;
      default:  base = 8'h01;  // byte, and the unused code 3
    endcase
    return base << off;
  endfunction

  // word not aligned, or half word crossing into the next word
  function automatic logic needs_split(logic [1:0] typ, logic [OFF_W-1:0] off);
    return ((typ == LSU_WORD) && (off != 2'd0)) ||
           ((typ == LSU_HALF) && (off == 2'd3));
  endfunction

  ////////////////////////////////////////////////////////////////////
  // write side
  ////////////////////////////////////////////////////////////////////

  assign be_first       = be_span(lsu_type_i, lsu_addr_lo_i);
  assign be_held        = be_span(data_type_q_i, rdata_offset_q_i);
  assign split_access_o = needs_split(lsu_type_i, lsu_addr_lo_i);

  // controller takes the spill selects at the first ack of a split
  assign spill_next = wb_ack_i & split_held & ~split_second_q_i;

  // spill half uses the upper nibble, moved down to the low lanes
  assign data_be_o = spill_next ? be_held[2*WB_SEL_W-1:WB_SEL_W]
                                : be_first[WB_SEL_W-1:0];

  // rotate left by offset; bytes past lane 3 wrap to the spill lanes
  always_comb begin
    case (lsu_addr_lo_i)
      2'd0:    data_wdata_o = lsu_wdata_i;
      2'd1:    data_wdata_o = {lsu_wdata_i[23:0], lsu_wdata_i[31:24]};
      2'd2:    data_wdata_o = {lsu_wdata_i[15:0], lsu_wdata_i[31:16]};
      default: data_wdata_o = {lsu_wdata_i[7:0],  lsu_wdata_i[31:8]};
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // read side
  ////////////////////////////////////////////////////////////////////

  // word: new low bytes on top of the held upper bytes
  always_comb begin
    case (rdata_offset_q_i)
      2'd0:    rdata_w = wb_rdata_i;
      2'd1:    rdata_w = {wb_rdata_i.b[0], rdata_q_i};
      2'd2:    rdata_w = {wb_rdata_i.h[0], rdata_q_i[23:8]};
      default: rdata_w = {wb_rdata_i.b[2], wb_rdata_i.b[1], wb_rdata_i.b[0],
                          rdata_q_i[23:16]};
    endcase
  end

  // half word lanes, offset 3 borrows the held top byte
  always_comb begin
    case (rdata_offset_q_i)
      2'd0:    half_raw = wb_rdata_i.h[0];
      2'd1:    half_raw = {wb_rdata_i.b[2], wb_rdata_i.b[1]};
      2'd2:    half_raw = wb_rdata_i.h[1];
      default: half_raw = {wb_rdata_i.b[0], rdata_q_i[23:16]};
    endcase
  end

  assign byte_raw = wb_rdata_i.b[rdata_offset_q_i];  // a byte never splits

  // size select and extension
  always_comb begin
    case (data_type_q_i)
      LSU_WORD: lsu_rdata_o = rdata_w;
      LSU_HALF: lsu_rdata_o = data_sign_ext_q_i ? {{16{half_raw[15]}}, half_raw}
                                                : {16'h0000, half_raw};
      default:  lsu_rdata_o = data_sign_ext_q_i ? {{24{byte_raw[7]}}, byte_raw}
                                                : {24'h00_0000, byte_raw};
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // response qualification
  ////////////////////////////////////////////////////////////////////

  assign split_held = needs_split(data_type_q_i, rdata_offset_q_i);
  assign final_half = ~split_held | split_second_q_i;
  assign resp       = (wb_ack_i & final_half) | wb_err_i;  // err always ends it
  assign any_err    = wb_err_i | err_q_i;

  assign lsu_rdata_valid_o = wb_ack_i & final_half & ~any_err & ~data_we_q_i;
  assign load_err_o        = any_err & resp & ~data_we_q_i;
  assign store_err_o       = any_err & resp &  data_we_q_i;

endmodule

`default_nettype wire

//--- hdl/lsu_ctrl.sv
/*
 * load/store controller: access FSM, misaligned split,
 * held access state and Wishbone classic master
 */

`timescale 1ns/100ps
`default_nettype none

module lsu_ctrl import lsu_pkg::*; import wb_pkg::*; #(
  parameter  int MEM_WORDS = MEM_WORDS_DEFAULT,
  localparam int ADR_W     = $clog2(MEM_WORDS) + 1  // top bit flags out of range
) (
  input  logic                clk_i,
  input  logic                rst_i,
  // core request
  input  logic                lsu_req_i,
  input  logic                lsu_we_i,
  input  logic [1:0]          lsu_type_i,
  input  logic [XLEN-1:0]     lsu_addr_i,
  input  logic                lsu_sign_ext_i,
  // bus response
  input  logic                wb_ack_i,
  input  logic                wb_err_i,
  input  lsu_word_u           wb_rdata_i,
  // from the alignment block
  input  logic                split_access_i,
  input  logic [WB_SEL_W-1:0] data_be_i,
  input  logic [XLEN-1:0]     data_wdata_i,
  // core status
  output logic                busy_o,
  output logic                lsu_resp_valid_o,
  output logic [XLEN-1:0]     addr_last_o,
  // Wishbone master
  output logic                wb_cyc_o,
  output logic                wb_stb_o,
  output logic                wb_we_o,
  output logic [ADR_W-1:0]    wb_adr_o,
  output logic [WB_SEL_W-1:0] wb_sel_o,
  output logic [XLEN-1:0]     wb_wdat_o,
  // held state to the alignment block
  output logic [23:0]         rdata_q_o,
  output logic [OFF_W-1:0]    rdata_offset_q_o,
  output logic [1:0]          data_type_q_o,
  output logic                data_sign_ext_q_o,
  output logic                data_we_q_o,
  output logic                split_second_q_o,
  output logic                err_q_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FIRST,   // first or only bus cycle
    ST_SECOND   // spill cycle of a split access
  } state_e;

  state_e                       state_q, state_d;
  logic                         split_q;
  logic                         split_second_q;
  logic                         err_q;
  logic                         we_q;
  logic [1:0]                   type_q;
  logic                         sign_q;
  logic [OFF_W-1:0]             off_q;
  logic [WB_SEL_W-1:0]          sel_q;
  logic [XLEN-1:0]              wdat_q;
  logic [XLEN-WB_ADR_LSB-1:0]   adr_word_q;  // full word address
  logic [XLEN-WB_ADR_LSB-1:0]   adr_next;
  logic [XLEN-1:0]              addr_last_q;
  lsu_word_u                    hold_q;      // first read word of a split load
  logic                         accept;
  logic                         first_done;
  logic                         go_second;
  logic                         resp;
  logic                         adr_over;

  ////////////////////////////////////////////////////////////////////
  // handshake and next state
  ////////////////////////////////////////////////////////////////////

  assign accept     = lsu_req_i & ~busy_o;
  assign first_done = (state_q == ST_FIRST) & (wb_err_i | (wb_ack_i & ~split_q));
  assign go_second  = (state_q == ST_FIRST) & wb_ack_i & split_q;
  assign resp       = first_done | ((state_q == ST_SECOND) & (wb_ack_i | wb_err_i));
  assign adr_next   = adr_word_q + 1'b1;

  assign busy_o           = (state_q != ST_IDLE) & ~resp;  // free in the response cycle
  assign lsu_resp_valid_o = resp;

  always_comb begin
    state_d = state_q;
    if (accept) begin
      state_d = ST_FIRST;      // back to back after a response
    end else if (go_second) begin
      state_d = ST_SECOND;
    end else if (resp) begin
      state_d = ST_IDLE;       // error on the first half lands here too
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q        <= ST_IDLE;
      split_q        <= 1'b0;
      split_second_q <= 1'b0;
      err_q          <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        split_q        <= split_access_i;
        split_second_q <= 1'b0;
        err_q          <= 1'b0;
      end else begin
        if (go_second) split_second_q <= 1'b1;
        if (wb_err_i && (state_q != ST_IDLE)) err_q <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // request fields and per-half payload
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (accept) begin
      we_q        <= lsu_we_i;
      type_q      <= lsu_type_i;
      sign_q      <= lsu_sign_ext_i;
      off_q       <= lsu_addr_i[OFF_W-1:0];
      adr_word_q  <= lsu_addr_i[XLEN-1:WB_ADR_LSB];
      addr_last_q <= lsu_addr_i;        // access address, first half
      sel_q       <= data_be_i;         // first half selects
      wdat_q      <= data_wdata_i;      // rotated, serves both halves
    end
    if (go_second) begin
      hold_q      <= wb_rdata_i;        // keep upper lanes for realignment
      sel_q       <= data_be_i;         // spill half selects
      adr_word_q  <= adr_next;
      addr_last_q <= {adr_next, {WB_ADR_LSB{1'b0}}};  // not touched on error
    end
  end

  ////////////////////////////////////////////////////////////////////
  // bus master
  ////////////////////////////////////////////////////////////////////

  // any word bit above the memory range forces the range flag
  assign adr_over = |adr_word_q[XLEN-WB_ADR_LSB-1:ADR_W-1];

  assign wb_cyc_o  = (state_q != ST_IDLE);
  assign wb_stb_o  = (state_q != ST_IDLE);   // held until ack or err
  assign wb_we_o   = we_q;
  assign wb_adr_o  = {adr_over, adr_word_q[ADR_W-2:0]};
  assign wb_sel_o  = sel_q;                  // selects of the current half
  assign wb_wdat_o = wdat_q;

  // held state out
  assign addr_last_o       = addr_last_q;
  assign rdata_q_o         = {hold_q.b[3], hold_q.b[2], hold_q.b[1]};
  assign rdata_offset_q_o  = off_q;
  assign data_type_q_o     = type_q;
  assign data_sign_ext_q_o = sign_q;
  assign data_we_q_o       = we_q;
  assign split_second_q_o  = split_second_q;
  assign err_q_o           = err_q;

endmodule

`default_nettype wire

//--- hdl/wb_data_ram.sv
/*
 * Wishbone classic slave word memory
 * byte-select writes, registered read data, range error
 */

`timescale 1ns/100ps
`default_nettype none

module wb_data_ram import lsu_pkg::*; import wb_pkg::*; #(
  parameter  int MEM_WORDS = MEM_WORDS_DEFAULT,
  localparam int ADR_W     = $clog2(MEM_WORDS) + 1
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                wb_cyc_i,
  input  logic                wb_stb_i,
  input  logic                wb_we_i,
  input  logic [ADR_W-1:0]    wb_adr_i,
  input  logic [WB_SEL_W-1:0] wb_sel_i,
  input  logic [XLEN-1:0]     wb_wdat_i,
  output logic                wb_ack_o,
  output logic                wb_err_o,
  output logic [XLEN-1:0]     wb_rdat_o
);

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic            ack_q, err_q;
  logic [XLEN-1:0] rdat_q;
  logic            hit;       // new strobe, not the one just answered
  logic            in_range;

  assign hit      = wb_cyc_i & wb_stb_i & ~ack_q & ~err_q;
  assign in_range = ~wb_adr_i[ADR_W-1];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= hit & in_range;
      err_q <= hit & ~in_range;  // memory left as is
    end
  end

  always_ff @(posedge clk_i) begin
    if (hit && in_range) begin
      rdat_q <= mem[wb_adr_i[ADR_W-2:0]];   // old contents on a write
      if (wb_we_i) begin
        for (int i = 0; i < WB_SEL_W; i++) begin
          if (wb_sel_i[i]) mem[wb_adr_i[ADR_W-2:0]][8*i +: 8] <= wb_wdat_i[8*i +: 8];
        end
      end
    end
  end

  assign wb_ack_o  = ack_q;
  assign wb_err_o  = err_q;
  assign wb_rdat_o = rdat_q;  // holds until the next accepted strobe

endmodule

`default_nettype wire

//--- hdl/lsu_sys_top.sv
/*
 * load/store unit top: controller, alignment block and data memory
 */

`timescale 1ns/100ps
`default_nettype none

module lsu_sys_top import lsu_pkg::*; import wb_pkg::*; #(
  parameter int MEM_WORDS = MEM_WORDS_DEFAULT
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            lsu_req_i,
  input  logic            lsu_we_i,
  input  logic [1:0]      lsu_type_i,
  input  logic [XLEN-1:0] lsu_addr_i,
  input  logic [XLEN-1:0] lsu_wdata_i,
  input  logic            lsu_sign_ext_i,
  output logic            busy_o,
  output logic            lsu_resp_valid_o,
  output logic [XLEN-1:0] lsu_rdata_o,
  output logic            lsu_rdata_valid_o,
  output logic            load_err_o,
  output logic            store_err_o,
  output logic [XLEN-1:0] addr_last_o
);

  localparam int ADR_W = $clog2(MEM_WORDS) + 1;

  // Wishbone
  logic                wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  logic [ADR_W-1:0]    wb_adr;
  logic [WB_SEL_W-1:0] wb_sel;
  logic [XLEN-1:0]     wb_wdat;
  lsu_word_u           wb_rdat;

  // controller <-> alignment
  logic                split_access;
  logic [WB_SEL_W-1:0] data_be;
  logic [XLEN-1:0]     data_wdata;
  logic [23:0]         rdata_q;
  logic [OFF_W-1:0]    rdata_offset_q;
  logic [1:0]          data_type_q;
  logic                data_sign_ext_q, data_we_q, split_second_q, err_q;

  lsu_ctrl #(.MEM_WORDS(MEM_WORDS)) u_ctrl (
    .clk_i, .rst_i, .lsu_req_i, .lsu_we_i, .lsu_type_i, .lsu_addr_i, .lsu_sign_ext_i,
    .wb_ack_i(wb_ack), .wb_err_i(wb_err), .wb_rdata_i(wb_rdat),
    .split_access_i(split_access), .data_be_i(data_be), .data_wdata_i(data_wdata),
    .busy_o, .lsu_resp_valid_o, .addr_last_o,
    .wb_cyc_o(wb_cyc), .wb_stb_o(wb_stb), .wb_we_o(wb_we), .wb_adr_o(wb_adr),
    .wb_sel_o(wb_sel), .wb_wdat_o(wb_wdat),
    .rdata_q_o(rdata_q), .rdata_offset_q_o(rdata_offset_q), .data_type_q_o(data_type_q),
    .data_sign_ext_q_o(data_sign_ext_q), .data_we_q_o(data_we_q),
    .split_second_q_o(split_second_q), .err_q_o(err_q)
  );

  lsu_align u_align (
    .lsu_type_i, .lsu_addr_lo_i(lsu_addr_i[OFF_W-1:0]), .lsu_wdata_i,
    .wb_rdata_i(wb_rdat), .wb_ack_i(wb_ack), .wb_err_i(wb_err),
    .rdata_q_i(rdata_q), .rdata_offset_q_i(rdata_offset_q), .data_type_q_i(data_type_q),
    .data_sign_ext_q_i(data_sign_ext_q), .data_we_q_i(data_we_q),
    .split_second_q_i(split_second_q), .err_q_i(err_q),
    .data_be_o(data_be), .data_wdata_o(data_wdata), .split_access_o(split_access),
    .lsu_rdata_o, .lsu_rdata_valid_o, .load_err_o, .store_err_o
  );

  wb_data_ram #(.MEM_WORDS(MEM_WORDS)) u_ram (
    .clk_i, .rst_i,
    .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
    .wb_sel_i(wb_sel), .wb_wdat_i(wb_wdat),
    .wb_ack_o(wb_ack), .wb_err_o(wb_err), .wb_rdat_o(wb_rdat)
  );

endmodule

`default_nettype wire

//--- verification/lsu_sys_assert.sv
/*
 * Wishbone classic master checks on the controller bus port,
 * attached to lsu_ctrl with bind
 */

`timescale 1ns/100ps
`default_nettype none

module lsu_sys_assert import lsu_pkg::*; import wb_pkg::*; #(
  parameter int ADR_W = $clog2(MEM_WORDS_DEFAULT) + 1
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [ADR_W-1:0]    adr_i,
  input  logic [WB_SEL_W-1:0] sel_i,
  input  logic [XLEN-1:0]     wdat_i,
  input  logic                ack_i,
  input  logic                err_i
);

  int unsigned fail_cnt = 0;  // failed checks so far

  // strobe only inside a bus cycle
  stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
    else begin
      $error("stb asserted without cyc");
      fail_cnt++;
    end

  // request held until the slave answers
  stb_held: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_i && !ack_i && !err_i |=> stb_i && $stable({we_i, adr_i, sel_i, wdat_i}))
    else begin
      $error("stb or bus fields changed before ack or err");
      fail_cnt++;
    end

  sel_nonzero: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> sel_i != '0)
    else begin
      $error("empty byte select under stb");
      fail_cnt++;
    end

endmodule

bind lsu_ctrl lsu_sys_assert #(.ADR_W(ADR_W)) u_bus_assert (
  .clk_i, .rst_i,
  .cyc_i(wb_cyc_o), .stb_i(wb_stb_o), .we_i(wb_we_o), .adr_i(wb_adr_o),
  .sel_i(wb_sel_o), .wdat_i(wb_wdat_o), .ack_i(wb_ack_i), .err_i(wb_err_i)
);

`default_nettype wire

//--- verification/lsu_sys_tb.sv
/*
 * load/store unit testbench: clock, reset, xorshift stimulus,
 * byte shadow memory, reference load model, response checker, report
 */

`timescale 1ns/100ps
`default_nettype none

module lsu_sys_tb import lsu_pkg::*; import wb_pkg::*; ();

  localparam int MEM_WORDS   = MEM_WORDS_DEFAULT;
  localparam int MEM_BYTES   = MEM_WORDS * 4;
  localparam int RST_CYCLES  = 16;
  localparam int RESP_WAIT   = 8;   // negedges allowed after acceptance
  localparam int N_WORD      = 32;
  localparam int N_SPLIT     = 24;
  localparam int N_RANGE     = 16;
  // fill, aligned pairs, lanes, splits, range errors, spill errors
  localparam int ACC_MAX     = MEM_WORDS + 2*N_WORD + 36 + 4*N_SPLIT + 2*N_RANGE + 12;
  localparam int CYCLE_LIMIT = ACC_MAX * 6 + RST_CYCLES;

  logic        clk, rst;
  logic        req, we, sign_ext;
  logic [1:0]  typ;
  logic [31:0] addr, wdata;
  logic        busy, resp_valid, rdata_valid, load_err, store_err;
  logic [31:0] rdata, addr_last;

  logic [7:0]  shadow [MEM_BYTES];   // byte image of the data memory
  logic        pending;              // access accepted, response not seen
  logic        exp_we, exp_err;
  logic [31:0] exp_rdata, exp_addr_last;
  int          exp_lat, acc_cyc;
  logic [31:0] rng;
  int          cycle_cnt, acc_cnt, resp_cnt, err_cnt, test_cnt;

  lsu_sys_top UUT (
    .clk_i(clk), .rst_i(rst), .lsu_req_i(req), .lsu_we_i(we), .lsu_type_i(typ),
    .lsu_addr_i(addr), .lsu_wdata_i(wdata), .lsu_sign_ext_i(sign_ext),
    .busy_o(busy), .lsu_resp_valid_o(resp_valid), .lsu_rdata_o(rdata),
    .lsu_rdata_valid_o(rdata_valid), .load_err_o(load_err), .store_err_o(store_err),
    .addr_last_o(addr_last)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= CYCLE_LIMIT);
    $display("timeout, run still going after %0d cycles", CYCLE_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic int access_size(logic [1:0] t);
    case (t)
      LSU_WORD: return 4;
      LSU_HALF: return 2;
      default:  return 1;  // code 3 reads as a byte
    endcase
  endfunction

  // access runs past byte 3 of its word
  function automatic logic crosses_word(logic [31:0] a, logic [1:0] t);
    return (int'(a[1:0]) + access_size(t)) > 4;
  endfunction

  // little-endian gather, then zero or sign fill above the top byte
  function automatic logic [31:0] ref_load(logic [31:0] a, logic [1:0] t, logic sx);
    int          n;
    logic [31:0] v;
    n = access_size(t);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = shadow[a + i];
    end
    if (sx && n < 4 && v[8*n-1]) v = v | (32'hffff_ffff << (8*n));
    return v;
  endfunction

  // bytes beyond the memory are dropped
  function automatic void ref_store(logic [31:0] a, logic [1:0] t, logic [31:0] d);
    for (int i = 0; i < access_size(t); i++) begin
      if (a + i < MEM_BYTES) shadow[a + i] = d[8*i +: 8];
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(string msg);
    $display("FAILED %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic bus_access(logic w, logic [1:0] t, logic [31:0] a, logic [31:0] d,
                            logic sx);
    logic        split, in_first;
    logic [31:0] scramble;
    int          waited;
    split         = crosses_word(a, t);
    in_first      = (a >> 2) < MEM_WORDS;
    exp_we        = w;
    exp_err       = (a + access_size(t) - 1) >= MEM_BYTES;
    exp_lat       = (split && in_first) ? 4 : 2;   // no second cycle after a first-half err
    exp_addr_last = (split && in_first) ? {a[31:2] + 30'd1, 2'b00} : a;
    exp_rdata     = (exp_err || w) ? '0 : ref_load(a, t, sx);
    if (w) ref_store(a, t, d);
    pending       = 1'b1;
    req      = 1'b1;
    we       = w;
    typ      = t;
    addr     = a;
    wdata    = d;
    sign_ext = sx;
    do @(posedge clk); while (busy);   // taken at the first edge with busy low
    acc_cyc = cycle_cnt;
    acc_cnt++;
    @(negedge clk);
    req      = 1'b0;
    scramble = rand32();               // fields are free once accepted
    we       = scramble[0];
    typ      = scramble[2:1];
    sign_ext = scramble[3];
    addr     = rand32();
    wdata    = rand32();
    waited   = 0;
    while (pending && waited < RESP_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (pending) begin
      $display("no response within %0d cycles for the access at %h", RESP_WAIT, a);
      err_cnt++;
      pending = 1'b0;
    end
  endtask

  task automatic store_to(logic [31:0] a, logic [1:0] t, logic [31:0] d);
    bus_access(1'b1, t, a, d, 1'b0);
  endtask

  task automatic load_from(logic [31:0] a, logic [1:0] t, logic sx);
    bus_access(1'b0, t, a, 32'h0, sx);
  endtask

  task automatic end_test(string name, int acc0, int err0);
    test_cnt++;
    $display("test %0d %s: %0d accesses, %0d errors", test_cnt, name,
             acc_cnt - acc0, err_cnt - err0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // response checker
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst && resp_valid) begin
      if (!pending) begin
        $display("response at %0t with no access outstanding", $time);
        err_cnt++;
      end else begin
        pending = 1'b0;
        resp_cnt++;
        assert (cycle_cnt - acc_cyc == exp_lat) else
          report_mismatch($sformatf("latency %0d, expected %0d", cycle_cnt - acc_cyc, exp_lat));
        assert (!busy) else report_mismatch("busy_o high in the response cycle");
        assert (addr_last == exp_addr_last) else
          report_mismatch($sformatf("addr_last %h, expected %h", addr_last, exp_addr_last));
        assert (load_err == (exp_err && !exp_we) && store_err == (exp_err && exp_we)) else
          report_mismatch($sformatf("load_err %b store_err %b, expected error %b on a %s",
                                    load_err, store_err, exp_err, exp_we ? "store" : "load"));
        assert (rdata_valid == (!exp_err && !exp_we)) else
          report_mismatch($sformatf("rdata_valid %b, wrong for this access", rdata_valid));
        if (!exp_err && !exp_we) begin
          assert (rdata == exp_rdata) else
            report_mismatch($sformatf("load data %h, expected %h", rdata, exp_rdata));
        end
      end
    end else if (!rst) begin
      assert (!load_err && !store_err && !rdata_valid) else
        report_mismatch("error or rdata valid outside a response");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          a0, e0, idx, sva_fail;
    logic [31:0] r, a, d;
    logic [1:0]  t;
    rng      = 32'd13;
    pending  = 1'b0;
    rst      = 1'b1;
    req      = 1'b0;
    we       = 1'b0;
    typ      = LSU_WORD;
    addr     = '0;
    wdata    = '0;
    sign_ext = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // reset state, then a known pattern in every word
    a0 = acc_cnt;
    e0 = err_cnt;
    assert (!busy && !resp_valid && !load_err && !store_err) else
      report_mismatch("busy, response or error high after reset");
    for (int w = 0; w < MEM_WORDS; w++) begin
      store_to(w * 4, LSU_WORD, w * 32'h9e37_79b1 ^ 32'h5a5a_0f0f);
    end
    end_test("reset and fill", a0, e0);

    a0 = acc_cnt;
    e0 = err_cnt;
    for (int i = 0; i < N_WORD; i++) begin
      a = (rand32() & (MEM_WORDS - 1)) << 2;
      store_to(a, LSU_WORD, rand32());
      load_from(a, LSU_WORD, 1'b0);
    end
    end_test("aligned words", a0, e0);

    // every lane, sign bit set on alternating cases
    a0 = acc_cnt;
    e0 = err_cnt;
    for (int off = 0; off < 4; off++) begin
      for (int k = 1; k < 4; k++) begin
        t     = k;
        a     = ((rand32() % (MEM_WORDS - 1)) << 2) + off;
        d     = rand32();
        d[7]  = off[0] ^ k[0];
        d[15] = off[0];
        store_to(a, t, d);
        load_from(a, t, 1'b0);
        load_from(a, t, 1'b1);
      end
    end
    end_test("byte and half lanes", a0, e0);

    a0 = acc_cnt;
    e0 = err_cnt;
    for (int i = 0; i < N_SPLIT; i++) begin
      r   = rand32();
      idx = rand32() % (MEM_WORDS - 1);
      if (r[0]) begin
        t = LSU_HALF;
        a = idx * 4 + 3;
      end else begin
        t = LSU_WORD;
        a = idx * 4 + 1 + (r[7:1] % 3);
      end
      store_to(a, t, rand32());
      load_from(a, t, r[8]);
      load_from(idx * 4, LSU_WORD, 1'b0);       // neighbours, first word
      load_from(idx * 4 + 4, LSU_WORD, 1'b0);   // and second word
    end
    end_test("split accesses", a0, e0);

    a0 = acc_cnt;
    e0 = err_cnt;
    for (int i = 0; i < N_RANGE; i++) begin
      r = rand32();
      a = MEM_BYTES + (rand32() & 32'h00ff_ffff);
      if (r[0]) begin
        store_to(a, r[2:1], rand32());
        load_from(a & (MEM_BYTES - 4), LSU_WORD, 1'b0);  // aliased word untouched
      end else begin
        load_from(a, r[2:1], r[3]);
      end
    end
    end_test("out of range", a0, e0);

    // last word in range, spill past the end
    a0 = acc_cnt;
    e0 = err_cnt;
    for (int c = 0; c < 4; c++) begin
      t = (c == 3) ? LSU_HALF : LSU_WORD;
      a = MEM_BYTES - 4 + ((c == 3) ? 3 : c + 1);
      store_to(a, t, rand32());
      load_from(MEM_BYTES - 4, LSU_WORD, 1'b0);
      load_from(a, t, 1'b1);
    end
    end_test("spill out of range", a0, e0);

    if (resp_cnt != acc_cnt) begin
      $display("accepted %0d requests but saw %0d responses", acc_cnt, resp_cnt);
      err_cnt++;
    end
    sva_fail = UUT.u_ctrl.u_bus_assert.fail_cnt;
    err_cnt += sva_fail;
    $display("tests %0d, accesses %0d, responses %0d, bus assertion failures %0d, errors %0d",
             test_cnt, acc_cnt, resp_cnt, sva_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- lsu_sys.f
hdl/lsu_pkg.sv
hdl/wb_pkg.sv
hdl/lsu_align.sv
hdl/lsu_ctrl.sv
hdl/wb_data_ram.sv
hdl/lsu_sys_top.sv
verification/lsu_sys_assert.sv
verification/lsu_sys_tb.sv
